// ==== sim.f ====
hw/corePkg.sv
hw/issueStage.sv
hw/regFile.sv
hw/aluUnit.sv
hw/fixedMemUnit.sv
hw/writebackArbiter.sv
hw/coreTop.sv
tb/clockGen.sv
tb/coreTb.sv

// ==== tb/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;
    logic              clk;
    logic              rstN;
    logic              instValid;
    logic [15:0]       instData;
    logic              instReady;
    corePkg::regWriteT regWrite;

    // Sequential reference model of registers and data memory
    corePkg::dataT     regModel [corePkg::regCount];
    corePkg::dataT     memModel [corePkg::memDepth];
    // Expected writes in program order, the first entry for a register is its head
    corePkg::regWriteT expQ [$];
    logic [31:0]       lfsr;
    string             currentTest;
    logic              sawStall;
    int                timeoutCycles = 2000;

    clockGen clk_i (
        .clk (clk),
        .rstN(rstN)
    );

    coreTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .instValid(instValid),
        .instData (instData),
        .instReady(instReady),
        .regWrite (regWrite)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("[ERROR] test %s: expected %h, actual %h",
                              testName, expected, actual));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        bitOut;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            bitOut = lfsr[0];
            lfsr = lfsr >> 1;
            if (bitOut) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            r = {r[30:0], bitOut};
        end
        return r;
    endfunction

    function automatic logic [15:0] regInst(input logic [3:0] op, input logic [3:0] a,
                                            input logic [3:0] b);
        return {op, a, b, 4'h0};
    endfunction

    function automatic logic [15:0] ldiInst(input logic [3:0] a, input logic [7:0] imm);
        return {corePkg::opLdi, a, imm};
    endfunction

    // Applies one instruction to the model and records the write it must produce
    task automatic runModel(input logic [15:0] inst);
        logic [3:0]        op;
        corePkg::regAddrT  a;
        corePkg::dataT     va;
        corePkg::dataT     vb;
        corePkg::dataT     res;
        logic              writes;
        corePkg::regWriteT entry;
        op = inst[15:12];
        a = inst[11:8];
        va = regModel[inst[11:8]];
        vb = regModel[inst[7:4]];
        res = '0;
        writes = 1'b1;
        case (op)
            corePkg::opAdd:   res = va + vb;
            corePkg::opSub:   res = va - vb;
            corePkg::opAnd:   res = va & vb;
            corePkg::opOr:    res = va | vb;
            corePkg::opXor:   res = va ^ vb;
            corePkg::opShl:   res = va << vb[3:0];
            corePkg::opShr:   res = va >> vb[3:0];
            corePkg::opLdi:   res = {8'h00, inst[7:0]};
            corePkg::opLoad:  res = memModel[vb[7:0]];
            corePkg::opStore: begin
                memModel[vb[7:0]] = va;
                writes = 1'b0;
            end
            default:          writes = 1'b0;
        endcase
        if (writes) begin
            regModel[a] = res;
            entry.en = 1'b1;
            entry.addr = a;
            entry.data = res;
            expQ.push_back(entry);
        end
    endtask

    task automatic checkWrite(input corePkg::regAddrT addr, input corePkg::dataT data);
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < expQ.size(); i++) begin
            if (idx < 0 && expQ[i].addr == addr) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            failRun($sformatf("Unexpected write to r%0d in test %s", addr, currentTest));
        end else begin
            checkValue(currentTest, 32'(expQ[idx].data), 32'(data));
            expQ.delete(idx);
        end
    endtask

    // Write port is driven from registers, so it is steady at the falling edge
    always @(negedge clk) begin
        if (rstN === 1'b1 && regWrite.en === 1'b1) begin
            checkWrite(regWrite.addr, regWrite.data);
        end
    end

    // Called at a falling edge, leaves instValid high for back-to-back sends
    task automatic sendInst(input logic [15:0] inst);
        int waited;
        waited = 0;
        runModel(inst);
        instValid = 1'b1;
        instData = inst;
        while (instReady !== 1'b1) begin
            sawStall = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) begin
                failRun($sformatf("Timeout: instruction %h was never accepted in test %s",
                                  inst, currentTest));
            end
        end
        @(negedge clk);
    endtask

    task automatic waitWrite();
        int waited;
        waited = 0;
        instValid = 1'b0;
        while (expQ.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > timeoutCycles) begin
                failRun($sformatf("Timeout: %0d register writes never arrived in test %s",
                                  expQ.size(), currentTest));
            end
        end
    endtask

    task automatic testLdiAll();
        int r;
        currentTest = "ldiAll";
        for (r = 0; r < corePkg::regCount; r++) begin
            sendInst(ldiInst(4'(r), 8'(r * 17 + 3)));
        end
        waitWrite();
    endtask

    task automatic testAluOps();
        logic [7:0] aVals [3];
        logic [7:0] bVals [3];
        int         op;
        int         p;
        currentTest = "aluOps";
        aVals = '{8'hC3, 8'h0F, 8'h01};
        bVals = '{8'h05, 8'hF0, 8'h0F};
        for (op = 1; op <= 7; op++) begin
            for (p = 0; p < 3; p++) begin
                sendInst(ldiInst(4'd1, aVals[p]));
                sendInst(ldiInst(4'd2, bVals[p]));
                sendInst(regInst(4'(op), 4'd1, 4'd2));
            end
        end
        waitWrite();
    endtask

    task automatic testStoreLoad();
        currentTest = "storeLoad";
        sendInst(ldiInst(4'd3, 8'h77));
        sendInst(ldiInst(4'd4, 8'h10));
        sendInst(regInst(corePkg::opStore, 4'd3, 4'd4));
        sendInst(regInst(corePkg::opLoad, 4'd5, 4'd4));
        // Address 0x20 is never stored before this point
        sendInst(ldiInst(4'd6, 8'h20));
        sendInst(regInst(corePkg::opLoad, 4'd7, 4'd6));
        waitWrite();
    endtask

    task automatic testLoadUse();
        currentTest = "loadUse";
        sendInst(ldiInst(4'd1, 8'h44));
        sendInst(ldiInst(4'd2, 8'h30));
        sendInst(regInst(corePkg::opStore, 4'd1, 4'd2));
        sendInst(regInst(corePkg::opLoad, 4'd9, 4'd2));
        sendInst(regInst(corePkg::opAdd, 4'd9, 4'd1));
        waitWrite();
    endtask

    task automatic testMemBurst();
        int i;
        currentTest = "memBurst";
        for (i = 0; i < 4; i++) begin
            sendInst(ldiInst(4'(i + 1), 8'(8'hA0 + i * 3)));
            sendInst(ldiInst(4'(i + 10), 8'(8'h40 + i)));
        end
        waitWrite();
        sawStall = 1'b0;
        for (i = 0; i < 4; i++) begin
            sendInst(regInst(corePkg::opStore, 4'(i + 1), 4'(i + 10)));
        end
        for (i = 0; i < 4; i++) begin
            sendInst(regInst(corePkg::opLoad, 4'(i + 5), 4'(i + 10)));
        end
        // Store of the register loaded last has to wait on the scoreboard
        sendInst(regInst(corePkg::opStore, 4'd8, 4'd10));
        sendInst(regInst(corePkg::opLoad, 4'd9, 4'd10));
        waitWrite();
        checkValue(currentTest, 32'd1, 32'(sawStall));
    endtask

    task automatic testRandomStream();
        logic [1:0]       kind;
        logic [3:0]       a;
        logic [3:0]       b;
        logic [3:0]       op;
        logic [15:0]      inst;
        int               n;
        currentTest = "randomStream";
        for (n = 0; n < 200; n++) begin
            kind = 2'(randBits(2));
            a = 4'(randBits(4));
            b = 4'(randBits(4));
            case (kind)
                2'd0: inst = ldiInst(a, 8'(randBits(8)));
                2'd1: begin
                    op = 4'((randBits(3) % 7) + 1);
                    inst = regInst(op, a, b);
                end
                2'd2: inst = regInst(corePkg::opLoad, a, b);
                default: inst = regInst(corePkg::opStore, a, b);
            endcase
            sendInst(inst);
        end
        waitWrite();
    endtask

    initial begin
        int waited;
        int i;
        instValid = 1'b0;
        instData = '0;
        lfsr = 32'hf942_5865;
        sawStall = 1'b0;
        currentTest = "reset";
        waited = 0;
        for (i = 0; i < corePkg::regCount; i++) begin
            regModel[i] = '0;
        end
        for (i = 0; i < corePkg::memDepth; i++) begin
            memModel[i] = '0;
        end
        while (rstN !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                failRun("Timeout: reset was never released");
            end
        end
        @(negedge clk);
        testLdiAll();
        testAluOps();
        testStoreLoad();
        testLoadUse();
        testMemBurst();
        testRandomStream();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// ==== hw/coreTop.sv ====
`timescale 1ns/1ps

module coreTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    input  logic [15:0]       instData,
    output logic              instReady,
    output corePkg::regWriteT regWrite
);
    corePkg::regAddrT             rdAddrA;
    corePkg::regAddrT             rdAddrB;
    corePkg::dataT                rdDataA;
    corePkg::dataT                rdDataB;
    logic [corePkg::regCount-1:0] dirty;
    corePkg::regWriteT            setDirty;
    corePkg::aluReqT              aluReq;
    logic                         memValid;
    corePkg::memReqT              memReq;
    logic                         memReady;
    corePkg::regWriteT            aluResult;
    corePkg::regWriteT            loadResult;
    logic                         loadAccept;

    issueStage issue_i (
        .clk      (clk),
        .rstN     (rstN),
        .instValid(instValid),
        .instData (instData),
        .instReady(instReady),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .dirty    (dirty),
        .setDirty (setDirty),
        .aluReq   (aluReq),
        .memValid (memValid),
        .memReq   (memReq),
        .memReady (memReady)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .setDirty(setDirty),
        .write   (regWrite),
        .dirty   (dirty)
    );

    // The two execution paths run side by side
    aluUnit alu_i (
        .clk      (clk),
        .rstN     (rstN),
        .aluReq   (aluReq),
        .aluResult(aluResult)
    );

    fixedMemUnit mem_i (
        .clk       (clk),
        .rstN      (rstN),
        .memValid  (memValid),
        .memReq    (memReq),
        .memReady  (memReady),
        .loadResult(loadResult),
        .loadAccept(loadAccept)
    );

    writebackArbiter wbArb_i (
        .aluResult (aluResult),
        .loadResult(loadResult),
        .loadAccept(loadAccept),
        .regWrite  (regWrite)
    );

endmodule

// ==== hw/writebackArbiter.sv ====
`timescale 1ns/1ps

module writebackArbiter (
    input  corePkg::regWriteT aluResult,
    input  corePkg::regWriteT loadResult,
    output logic              loadAccept,
    output corePkg::regWriteT regWrite
);

    // ALU results cannot stall, so they always get the port
    assign loadAccept = loadResult.en && !aluResult.en;

    always_comb begin
        if (aluResult.en) begin
            regWrite = aluResult;
        end else if (loadResult.en) begin
            regWrite = loadResult;
        end else begin
            regWrite = '0;
        end
    end

endmodule

// ==== hw/fixedMemUnit.sv ====
`timescale 1ns/1ps

module fixedMemUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memValid,
    input  corePkg::memReqT   memReq,
    output logic              memReady,
    output corePkg::regWriteT loadResult,
    input  logic              loadAccept
);
    corePkg::memReqT                      queue [corePkg::memQueueDepth];
    logic [corePkg::memQueuePtrWidth-1:0] wrPtr;
    logic [corePkg::memQueuePtrWidth-1:0] rdPtr;
    logic [corePkg::memQueuePtrWidth:0]   count;
    corePkg::dataT                        mem [corePkg::memDepth];
    corePkg::memReqT                      head;
    logic                                 push;
    logic                                 pop;
    logic                                 resValid;
    corePkg::regAddrT                     resDest;
    corePkg::dataT                        resData;

    assign memReady = (count != (corePkg::memQueuePtrWidth + 1)'(corePkg::memQueueDepth));
    assign push     = memValid && memReady;
    assign head     = queue[rdPtr];

    // Stores always drain, a load waits until the result register is free
    assign pop = (count != '0) && (head.isStore || !resValid || loadAccept);

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wrPtr] <= memReq;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Data memory starts out cleared
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < corePkg::memDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (pop && head.isStore) begin
            mem[head.addr] <= head.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (pop && !head.isStore) begin
            resValid <= 1'b1;
        end else if (loadAccept) begin
            resValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !head.isStore) begin
            resDest <= head.dest;
            resData <= mem[head.addr];
        end
    end

    assign loadResult.en   = resValid;
    assign loadResult.addr = resDest;
    assign loadResult.data = resData;

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  logic              clk,
    input  logic              rstN,
    input  corePkg::aluReqT   aluReq,
    output corePkg::regWriteT aluResult
);
    corePkg::dataT    result;
    logic             resEn;
    corePkg::regAddrT resAddr;
    corePkg::dataT    resData;

    // Arithmetic wraps, shifts are logical by the low 4 bits of b
    always_comb begin
        case (aluReq.op)
            corePkg::opAdd: result = aluReq.a + aluReq.b;
            corePkg::opSub: result = aluReq.a - aluReq.b;
            corePkg::opAnd: result = aluReq.a & aluReq.b;
            corePkg::opOr:  result = aluReq.a | aluReq.b;
            corePkg::opXor: result = aluReq.a ^ aluReq.b;
            corePkg::opShl: result = aluReq.a << aluReq.b[3:0];
            corePkg::opShr: result = aluReq.a >> aluReq.b[3:0];
            corePkg::opLdi: result = aluReq.b;
            default:        result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resEn <= 1'b0;
        end else begin
            resEn <= aluReq.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (aluReq.valid) begin
            resAddr <= aluReq.dest;
            resData <= result;
        end
    end

    assign aluResult.en   = resEn;
    assign aluResult.addr = resAddr;
    assign aluResult.data = resData;

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  corePkg::regAddrT             rdAddrA,
    input  corePkg::regAddrT             rdAddrB,
    output corePkg::dataT                rdDataA,
    output corePkg::dataT                rdDataB,
    input  corePkg::regWriteT            setDirty,
    input  corePkg::regWriteT            write,
    output logic [corePkg::regCount-1:0] dirty
);
    corePkg::dataT regs [corePkg::regCount];

    // Combinational read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < corePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en) begin
            regs[write.addr] <= write.data;
        end
    end

    // One scoreboard bit per register
    // A new dispatch marking a register busy beats a retiring write to it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dirty <= '0;
        end else begin
            for (int i = 0; i < corePkg::regCount; i++) begin
                if (setDirty.en && (setDirty.addr == corePkg::regAddrT'(i))) begin
                    dirty[i] <= 1'b1;
                end else if (write.en && (write.addr == corePkg::regAddrT'(i))) begin
                    dirty[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/issueStage.sv ====
`timescale 1ns/1ps

module issueStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instValid,
    input  logic [15:0]                  instData,
    output logic                         instReady,
    output corePkg::regAddrT             rdAddrA,
    output corePkg::regAddrT             rdAddrB,
    input  corePkg::dataT                rdDataA,
    input  corePkg::dataT                rdDataB,
    input  logic [corePkg::regCount-1:0] dirty,
    output corePkg::regWriteT            setDirty,
    output corePkg::aluReqT              aluReq,
    output logic                         memValid,
    output corePkg::memReqT              memReq,
    input  logic                         memReady
);
    corePkg::instT   inInst;
    corePkg::opcodeE inOp;
    corePkg::instT   heldInst;
    corePkg::opcodeE heldOp;
    logic            heldValid;
    logic            started;
    logic            isAlu;
    logic            isMem;
    logic            needA;
    logic            needB;
    logic            writesReg;
    logic            srcClear;
    logic            dispatch;
    logic            accept;

    assign inInst = instData;

    // Unknown opcodes fall back to NOP here
    always_comb begin
        case (inInst.opcode)
            corePkg::opAdd, corePkg::opSub, corePkg::opAnd, corePkg::opOr,
            corePkg::opXor, corePkg::opShl, corePkg::opShr, corePkg::opLdi,
            corePkg::opLoad, corePkg::opStore: inOp = corePkg::opcodeE'(inInst.opcode);
            default: inOp = corePkg::opNop;
        endcase
    end

    // Path selection and which registers take part in the hazard check
    always_comb begin
        isAlu = 1'b0;
        isMem = 1'b0;
        needA = 1'b0;
        needB = 1'b0;
        case (heldOp)
            corePkg::opAdd, corePkg::opSub, corePkg::opAnd, corePkg::opOr,
            corePkg::opXor, corePkg::opShl, corePkg::opShr: begin
                isAlu = 1'b1;
                needA = 1'b1;
                needB = 1'b1;
            end
            corePkg::opLdi: begin
                isAlu = 1'b1;
                needA = 1'b1;
            end
            corePkg::opLoad, corePkg::opStore: begin
                isMem = 1'b1;
                needA = 1'b1;
                needB = 1'b1;
            end
            default: ;
        endcase
    end

    assign writesReg = isAlu || (heldOp == corePkg::opLoad);
    assign srcClear  = !(needA && dirty[heldInst.regA]) && !(needB && dirty[heldInst.regB]);
    assign dispatch  = heldValid && srcClear && (!isMem || memReady);
    assign instReady = started && (!heldValid || dispatch);
    assign accept    = instValid && instReady;

    assign rdAddrA = heldInst.regA;
    assign rdAddrB = heldInst.regB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            started   <= 1'b0;
            heldValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                heldValid <= 1'b1;
            end else if (dispatch) begin
                heldValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldInst <= inInst;
            heldOp   <= inOp;
        end
    end

    // Destination goes busy at the dispatch edge
    assign setDirty.en   = dispatch && writesReg;
    assign setDirty.addr = heldInst.regA;
    assign setDirty.data = '0;

    assign aluReq.valid = dispatch && isAlu;
    assign aluReq.op    = heldOp;
    assign aluReq.dest  = heldInst.regA;
    assign aluReq.a     = rdDataA;
    assign aluReq.b     = (heldOp == corePkg::opLdi) ?
                          corePkg::dataT'({heldInst.regB, heldInst.immLow}) : rdDataB;

    assign memValid        = heldValid && isMem && srcClear;
    assign memReq.isStore  = (heldOp == corePkg::opStore);
    assign memReq.dest     = heldInst.regA;
    assign memReq.addr     = rdDataB[corePkg::memAddrWidth-1:0];
    assign memReq.data     = rdDataA;

endmodule

// ==== hw/corePkg.sv ====
package corePkg;

    localparam int dataWidth = 16;
    localparam int regCount = 16;
    localparam int regAddrWidth = 4;
    localparam int memDepth = 256;
    localparam int memAddrWidth = 8;
    localparam int memQueueDepth = 4;
    localparam int memQueuePtrWidth = $clog2(memQueueDepth);

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [regAddrWidth-1:0] regAddrT;
    typedef logic [memAddrWidth-1:0] memAddrT;

    // Encodings above opStore are decoded as NOP
    typedef enum logic [3:0] {
        opNop   = 4'h0,
        opAdd   = 4'h1,
        opSub   = 4'h2,
        opAnd   = 4'h3,
        opOr    = 4'h4,
        opXor   = 4'h5,
        opShl   = 4'h6,
        opShr   = 4'h7,
        opLdi   = 4'h8,
        opLoad  = 4'h9,
        opStore = 4'hA
    } opcodeE;

    // Raw instruction word, LDI immediate is {regB, immLow}
    typedef struct packed {
        logic [3:0] opcode;
        regAddrT    regA;
        regAddrT    regB;
        logic [3:0] immLow;
    } instT;

    typedef struct packed {
        logic    valid;
        opcodeE  op;
        regAddrT dest;
        dataT    a;
        dataT    b;
    } aluReqT;

    typedef struct packed {
        logic    isStore;
        regAddrT dest;
        memAddrT addr;
        dataT    data;
    } memReqT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
        dataT    data;
    } regWriteT;

endpackage
